//--- all.f
+incdir+include
hw/axi_ls_pkg.sv
hw/axi_ls_bridge.sv
hw/axi_sram_slave.sv
hw/axi_ls_top.sv
tests/tb_clock_gen.sv
tests/tb_axi_ls.sv

//--- hw/axi_ls_bridge.sv
`timescale 1ns/1ps

module axi_ls_bridge
    import axi_ls_pkg::*;
(
    input  logic            clock,
    input  logic            reset,

    input  logic            wr_valid_i,
    input  logic            rw_valid_i,
    input  logic [XLEN-1:0] rw_addr_i,
    input  logic [XLEN-1:0] rw_w_data_i,
    input  logic [AXI_STRB_W-1:0] rw_w_mask_i,
    input  logic [2:0]      wr_size_i,
    output logic            wr_ok_o,
    output logic            rw_ready_o,
    output logic [XLEN-1:0] data_read_o,

    output axi_aw_t         aw_req_o,
    output logic            aw_valid_o,
    input  logic            aw_ready_i,
    output axi_w_t          w_req_o,
    output logic            w_valid_o,
    input  logic            w_ready_i,
    input  axi_b_t          b_rsp_i,
    input  logic            b_valid_i,
    output logic            b_ready_o,
    output axi_ar_t         ar_req_o,
    output logic            ar_valid_o,
    input  logic            ar_ready_i,
    input  axi_r_t          r_rsp_i,
    input  logic            r_valid_i,
    output logic            r_ready_o
);

    localparam logic [AXI_ID_W-1:0] BRIDGE_ID = 4'd1;

    w_state_e        w_state;
    w_state_e        w_state_next;
    r_state_e        r_state;
    r_state_e        r_state_next;
    logic [XLEN-1:0] addr_q;     // address in flight, shared by both directions
    logic [XLEN-1:0] rd_data_q;
    logic            b_seen_q;   // write response arrived
    logic            addr_hit;
    logic [2:0]      lane;

    assign addr_hit = (rw_addr_i == addr_q);
    assign lane     = rw_addr_i[2:0];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state   <= w_idle;
            r_state   <= r_idle;
            addr_q    <= '0;
            rd_data_q <= '0;
            b_seen_q  <= 1'b0;
        end else begin
            w_state <= w_state_next;
            r_state <= r_state_next;
            if (w_state == w_aw_wait || r_state == r_ar_wait) begin
                addr_q <= rw_addr_i;
            end
            if (w_state == w_b_done && b_valid_i) begin
                b_seen_q <= 1'b1;
            end else if (w_state != w_b_done) begin
                b_seen_q <= 1'b0;
            end
            if (r_valid_i && r_ready_o) begin
                rd_data_q <= r_rsp_i.data;
            end
        end
    end

    // write sequence: aw, then w, then wait for b
    always_comb begin
        w_state_next = w_state;
        case (w_state)
            w_idle: begin
                if (wr_valid_i) begin
                    w_state_next = w_aw_wait;
                end
            end
            w_aw_wait: begin
                if (aw_ready_i) begin
                    w_state_next = w_w_wait;
                end
            end
            w_w_wait: begin
                if (w_ready_i) begin
                    w_state_next = w_b_done;
                end
            end
            w_b_done: begin
                // leave only once the response is in
                if (b_seen_q && !wr_valid_i) begin
                    w_state_next = w_idle;
                end else if (b_seen_q && !addr_hit) begin
                    w_state_next = w_aw_wait; // new address while held
                end
            end
            default: w_state_next = w_idle;
        endcase
    end

    always_comb begin
        r_state_next = r_state;
        case (r_state)
            r_idle: begin
                if (rw_valid_i) begin
                    r_state_next = r_ar_wait;
                end
            end
            r_ar_wait: begin
                if (ar_ready_i) begin
                    r_state_next = r_r_wait;
                end
            end
            r_r_wait: begin
                if (r_valid_i) begin
                    r_state_next = r_r_done;
                end
            end
            r_r_done: begin
                if (!rw_valid_i) begin
                    r_state_next = r_idle;
                end else if (!addr_hit) begin
                    r_state_next = r_ar_wait;
                end
            end
            default: r_state_next = r_idle;
        endcase
    end

    assign aw_valid_o = (w_state == w_aw_wait);
    assign w_valid_o  = (w_state == w_w_wait);
    assign b_ready_o  = (w_state == w_b_done) && b_valid_i;
    assign ar_valid_o = (r_state == r_ar_wait);
    assign r_ready_o  = (r_state == r_r_wait);

    // done levels drop as soon as the request or address moves
    assign wr_ok_o     = (w_state == w_b_done) && b_seen_q && wr_valid_i && addr_hit;
    assign rw_ready_o  = (r_state == r_r_done) && rw_valid_i && addr_hit;
    assign data_read_o = rw_ready_o ? rd_data_q : '0;

    assign aw_req_o = '{
        addr:   {rw_addr_i[XLEN-1:3], 3'b000}, // 8-byte aligned
        id:     BRIDGE_ID,
        len:    8'd0,
        size:   wr_size_i,
        burst:  axi_burst_incr,
        lock:   1'b0,
        cache:  AXI_CACHE_WR,
        prot:   AXI_PROT_DEFAULT,
        qos:    4'd0,
        region: 4'd0
    };

    // data moves by whole bytes, strobe by one bit per byte
    assign w_req_o = '{
        data: rw_w_data_i << {lane, 3'b000},
        strb: rw_w_mask_i << lane,
        last: 1'b1
    };

    assign ar_req_o = '{
        addr:   rw_addr_i,
        id:     BRIDGE_ID,
        len:    8'd0,
        size:   3'd3,   // always a full word
        burst:  axi_burst_incr,
        lock:   1'b0,
        cache:  AXI_CACHE_RD,
        prot:   AXI_PROT_DEFAULT,
        qos:    4'd0,
        region: 4'd0
    };

endmodule

//--- hw/axi_ls_pkg.sv
package axi_ls_pkg;

    // core and bus widths
    localparam int XLEN       = 64;
    localparam int AXI_DATA_W = 64;
    localparam int AXI_ADDR_W = 64;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // attributes the bridge drives on every request
    localparam logic [2:0] AXI_PROT_DEFAULT = 3'b000;  // unprivileged, secure, data
    localparam logic [3:0] AXI_CACHE_RD     = 4'b0010; // normal non-cacheable
    localparam logic [3:0] AXI_CACHE_WR     = 4'b1111; // write-back, r/w allocate

    typedef enum logic [1:0] {
        axi_burst_fixed = 2'b00,
        axi_burst_incr  = 2'b01,
        axi_burst_wrap  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        axi_resp_okay   = 2'b00,
        axi_resp_exokay = 2'b01,
        axi_resp_slverr = 2'b10,
        axi_resp_decerr = 2'b11
    } axi_resp_e;

    // address channel payload, shared layout for aw and ar
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_ID_W-1:0]   id;
        logic [7:0]            len;
        logic [2:0]            size;
        axi_burst_e            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
        logic [3:0]            qos;
        logic [3:0]            region;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        axi_resp_e           resp;
    } axi_b_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_ID_W-1:0]   id;
        axi_resp_e             resp;
        logic                  last;
    } axi_r_t;

    // bridge state machines
    typedef enum logic [1:0] {
        w_idle    = 2'b00,
        w_aw_wait = 2'b01,
        w_w_wait  = 2'b11,
        w_b_done  = 2'b10
    } w_state_e;

    typedef enum logic [1:0] {
        r_idle    = 2'b00,
        r_ar_wait = 2'b01,
        r_r_wait  = 2'b11,
        r_r_done  = 2'b10
    } r_state_e;

endpackage

//--- hw/axi_ls_top.sv
`timescale 1ns/1ps

module axi_ls_top
    import axi_ls_pkg::*;
#(
    parameter int MEM_WORDS = 64,
    parameter int AW_WAIT   = 2,
    parameter int W_WAIT    = 1,
    parameter int AR_WAIT   = 2,
    parameter int R_WAIT    = 3,
    parameter int B_WAIT    = 1
)(
    input  logic            clock,
    input  logic            reset,
    input  logic            wr_valid_i,
    input  logic            rw_valid_i,
    input  logic [XLEN-1:0] rw_addr_i,
    input  logic [XLEN-1:0] rw_w_data_i,
    input  logic [AXI_STRB_W-1:0] rw_w_mask_i,
    input  logic [2:0]      wr_size_i,
    output logic            wr_ok_o,
    output logic            rw_ready_o,
    output logic [XLEN-1:0] data_read_o
);

    // bridge to memory channels
    axi_aw_t aw_req;
    axi_w_t  w_req;
    axi_b_t  b_rsp;
    axi_ar_t ar_req;
    axi_r_t  r_rsp;
    logic    aw_valid;
    logic    aw_ready;
    logic    w_valid;
    logic    w_ready;
    logic    b_valid;
    logic    b_ready;
    logic    ar_valid;
    logic    ar_ready;
    logic    r_valid;
    logic    r_ready;

    axi_ls_bridge axi_ls_bridge_inst (
        .clock       (clock),
        .reset       (reset),
        .wr_valid_i  (wr_valid_i),
        .rw_valid_i  (rw_valid_i),
        .rw_addr_i   (rw_addr_i),
        .rw_w_data_i (rw_w_data_i),
        .rw_w_mask_i (rw_w_mask_i),
        .wr_size_i   (wr_size_i),
        .wr_ok_o     (wr_ok_o),
        .rw_ready_o  (rw_ready_o),
        .data_read_o (data_read_o),
        .aw_req_o (aw_req), .aw_valid_o (aw_valid), .aw_ready_i (aw_ready),
        .w_req_o  (w_req),  .w_valid_o  (w_valid),  .w_ready_i  (w_ready),
        .b_rsp_i  (b_rsp),  .b_valid_i  (b_valid),  .b_ready_o  (b_ready),
        .ar_req_o (ar_req), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
        .r_rsp_i  (r_rsp),  .r_valid_i  (r_valid),  .r_ready_o  (r_ready)
    );

    axi_sram_slave #(
        .MEM_WORDS (MEM_WORDS),
        .AW_WAIT   (AW_WAIT),
        .W_WAIT    (W_WAIT),
        .AR_WAIT   (AR_WAIT),
        .R_WAIT    (R_WAIT),
        .B_WAIT    (B_WAIT)
    ) axi_sram_slave_inst (
        .clock (clock),
        .reset (reset),
        .aw_req_i (aw_req), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
        .w_req_i  (w_req),  .w_valid_i  (w_valid),  .w_ready_o  (w_ready),
        .b_rsp_o  (b_rsp),  .b_valid_o  (b_valid),  .b_ready_i  (b_ready),
        .ar_req_i (ar_req), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
        .r_rsp_o  (r_rsp),  .r_valid_o  (r_valid),  .r_ready_i  (r_ready)
    );

endmodule

//--- hw/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave
    import axi_ls_pkg::*;
#(
    parameter int MEM_WORDS = 64,
    parameter int AW_WAIT   = 2,
    parameter int W_WAIT    = 1,
    parameter int AR_WAIT   = 2,
    parameter int R_WAIT    = 3,
    parameter int B_WAIT    = 1
)(
    input  logic    clock,
    input  logic    reset,

    input  axi_aw_t aw_req_i,
    input  logic    aw_valid_i,
    output logic    aw_ready_o,
    input  axi_w_t  w_req_i,
    input  logic    w_valid_i,
    output logic    w_ready_o,
    output axi_b_t  b_rsp_o,
    output logic    b_valid_o,
    input  logic    b_ready_i,
    input  axi_ar_t ar_req_i,
    input  logic    ar_valid_i,
    output logic    ar_ready_o,
    output axi_r_t  r_rsp_o,
    output logic    r_valid_o,
    input  logic    r_ready_i
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [AXI_DATA_W-1:0] mem [MEM_WORDS];

    logic [7:0]          aw_cnt;
    logic [7:0]          w_cnt;
    logic [7:0]          b_cnt;
    logic [7:0]          ar_cnt;
    logic [7:0]          r_cnt;
    logic                aw_open;  // address taken, response not yet sent
    logic                w_done;   // data written, response pending
    logic                ar_open;
    logic [IDX_W-1:0]    aw_idx_q;
    logic [IDX_W-1:0]    ar_idx_q;
    logic [AXI_ID_W-1:0] aw_id_q;
    logic [AXI_ID_W-1:0] ar_id_q;

    assign aw_ready_o = aw_valid_i && !aw_open && (aw_cnt == 8'(AW_WAIT));
    assign w_ready_o  = w_valid_i && aw_open && !w_done && (w_cnt == 8'(W_WAIT));
    assign b_valid_o  = w_done && (b_cnt >= 8'(B_WAIT));
    assign ar_ready_o = ar_valid_i && !ar_open && (ar_cnt == 8'(AR_WAIT));
    assign r_valid_o  = ar_open && (r_cnt >= 8'(R_WAIT));

    assign b_rsp_o = '{id: aw_id_q, resp: axi_resp_okay};
    assign r_rsp_o = '{data: mem[ar_idx_q], id: ar_id_q, resp: axi_resp_okay, last: 1'b1};

    // write side wait counters and flags
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            aw_cnt  <= '0;
            w_cnt   <= '0;
            b_cnt   <= '0;
            aw_open <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (aw_valid_i && aw_ready_o) begin
                aw_open <= 1'b1;
                aw_cnt  <= '0;
            end else if (aw_valid_i && !aw_open) begin
                aw_cnt <= aw_cnt + 8'd1;
            end
            if (w_valid_i && w_ready_o) begin
                w_done <= 1'b1;
                w_cnt  <= '0;
                b_cnt  <= 8'd1; // transfer cycle counts toward the b wait
            end else if (w_valid_i && aw_open && !w_done) begin
                w_cnt <= w_cnt + 8'd1;
            end else if (w_done && !b_valid_o) begin
                b_cnt <= b_cnt + 8'd1;
            end
            if (b_valid_o && b_ready_i) begin
                aw_open <= 1'b0;
                w_done  <= 1'b0;
                b_cnt   <= '0;
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_cnt  <= '0;
            r_cnt   <= '0;
            ar_open <= 1'b0;
        end else begin
            if (ar_valid_i && ar_ready_o) begin
                ar_open <= 1'b1;
                ar_cnt  <= '0;
                r_cnt   <= 8'd1;
            end else if (ar_valid_i && !ar_open) begin
                ar_cnt <= ar_cnt + 8'd1;
            end else if (ar_open && !r_valid_o) begin
                r_cnt <= r_cnt + 8'd1;
            end
            if (r_valid_o && r_ready_i) begin
                ar_open <= 1'b0;
                r_cnt   <= '0;
            end
        end
    end

    // request payload, held for the response
    always_ff @(posedge clock) begin
        if (aw_valid_i && aw_ready_o) begin
            aw_idx_q <= aw_req_i.addr[3 +: IDX_W];
            aw_id_q  <= aw_req_i.id;
        end
        if (ar_valid_i && ar_ready_o) begin
            ar_idx_q <= ar_req_i.addr[3 +: IDX_W];
            ar_id_q  <= ar_req_i.id;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (w_valid_i && w_ready_o) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (w_req_i.strb[b]) begin
                    mem[aw_idx_q][8*b +: 8] <= w_req_i.data[8*b +: 8]; // byte lane b
                end
            end
        end
    end

endmodule

//--- include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one core request per row
typedef struct packed {
    logic        is_write;
    logic [63:0] addr;
    logic [63:0] data;
    logic [7:0]  mask;
    logic [2:0]  size;
} tb_op_t;

localparam int TB_NUM_OPS = 16;

// rows whose data is replaced by a random word
localparam logic [TB_NUM_OPS-1:0] TB_RANDOM_ROWS = 16'h2100; // rows 8 and 13

localparam tb_op_t TB_OPS [TB_NUM_OPS] = '{
    '{1'b0, 64'h000, 64'h0,                   8'h00, 3'd3}, // unwritten word
    '{1'b1, 64'h000, 64'h1122_3344_5566_7788, 8'hff, 3'd3},
    '{1'b0, 64'h000, 64'h0,                   8'h00, 3'd3},
    '{1'b1, 64'h001, 64'h0000_0000_0000_00ab, 8'h01, 3'd0}, // byte at offset 1
    '{1'b1, 64'h002, 64'h0000_0000_0000_beef, 8'h03, 3'd1}, // half at offset 2
    '{1'b1, 64'h005, 64'h0000_0000_0000_00cd, 8'h01, 3'd0},
    '{1'b1, 64'h006, 64'h0000_0000_0000_1357, 8'h03, 3'd1},
    '{1'b0, 64'h000, 64'h0,                   8'h00, 3'd3}, // merged word
    '{1'b1, 64'h0c0, 64'h0,                   8'hff, 3'd3},
    '{1'b1, 64'h048, 64'hdead_beef_0bad_f00d, 8'hff, 3'd3}, // held into next row
    '{1'b1, 64'h050, 64'h0123_4567_89ab_cdef, 8'hff, 3'd3},
    '{1'b0, 64'h048, 64'h0,                   8'h00, 3'd3},
    '{1'b0, 64'h050, 64'h0,                   8'h00, 3'd3},
    '{1'b1, 64'h0c8, 64'h0,                   8'hff, 3'd3},
    '{1'b0, 64'h0c0, 64'h0,                   8'h00, 3'd3},
    '{1'b0, 64'h0c8, 64'h0,                   8'h00, 3'd3}
};

`endif

//--- tests/tb_axi_ls.sv
`timescale 1ns/1ps

module tb_axi_ls;

    `include "tb_vectors.svh"

    localparam int RESET_CYCLES = 10;
    localparam int MODEL_WORDS  = 64;   // default memory depth
    localparam int HELD_ROW     = 9;    // write stays up into the next row
    localparam int HOLD_CYCLES  = 3;
    localparam int DONE_LIMIT   = 30;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TB_NUM_OPS * 40 + 100;

    logic        clock;
    logic        reset;
    logic        wr_valid;
    logic        rw_valid;
    logic [63:0] rw_addr;
    logic [63:0] rw_w_data;
    logic [7:0]  rw_w_mask;
    logic [2:0]  wr_size;
    logic        wr_ok;
    logic        rw_ready;
    logic [63:0] data_read;

    logic [7:0]  ref_mem [MODEL_WORDS*8]; // byte image of the memory
    tb_op_t      ops [TB_NUM_OPS];
    int          cycles = 0;
    int          checks;
    int          errors;
    int          row_errors;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_inst (
        .clock_o (clock),
        .reset_o (reset)
    );

    axi_ls_top axi_ls_top_inst (
        .clock       (clock),
        .reset       (reset),
        .wr_valid_i  (wr_valid),
        .rw_valid_i  (rw_valid),
        .rw_addr_i   (rw_addr),
        .rw_w_data_i (rw_w_data),
        .rw_w_mask_i (rw_w_mask),
        .wr_size_i   (wr_size),
        .wr_ok_o     (wr_ok),
        .rw_ready_o  (rw_ready),
        .data_read_o (data_read)
    );

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a request is stuck", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            row_errors++;
            $display("** Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    // mask and data move up by the low address bits
    function automatic void apply_write(input tb_op_t op);
        logic [2:0]  lane;
        logic [7:0]  strb;
        logic [63:0] data;
        int          base;
        lane = op.addr[2:0];
        strb = op.mask << lane;
        data = op.data << (lane * 8);
        base = int'((op.addr >> 3) % MODEL_WORDS) * 8;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                ref_mem[base + b] = data[8*b +: 8];
            end
        end
    endfunction

    function automatic logic [63:0] predict_read(input logic [63:0] addr);
        logic [63:0] word;
        int          base;
        base = int'((addr >> 3) % MODEL_WORDS) * 8;
        for (int b = 0; b < 8; b++) begin
            word[8*b +: 8] = ref_mem[base + b];
        end
        return word;
    endfunction

    function automatic logic done_level(input logic is_write);
        return is_write ? wr_ok : rw_ready;
    endfunction

    task automatic drive_row(input tb_op_t op);
        wr_valid  = op.is_write;
        rw_valid  = !op.is_write;
        rw_addr   = op.addr;
        rw_w_data = op.data;
        rw_w_mask = op.mask;
        wr_size   = op.size;
    endtask

    task automatic wait_done(input logic is_write, output bit seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < DONE_LIMIT) begin
            @(negedge clock);
            n++;
            if (done_level(is_write)) begin
                seen = 1'b1;
            end
        end
    endtask

    initial begin
        tb_op_t      op;
        bit          seen;
        bit          prev_held;
        logic [63:0] expect_data;
        string       done_name;
        int          discard;
        int          reset_edges;
        wr_valid    = 1'b1;   // requests raised under reset
        rw_valid    = 1'b0;
        rw_addr     = '0;     // first row reads address zero
        rw_w_data   = '0;
        rw_w_mask   = '0;
        wr_size     = '0;
        checks      = 0;
        errors      = 0;
        row_errors  = 0;
        prev_held   = 1'b0;
        reset_edges = 0;
        discard     = $urandom(32'h204e_5a53); // seed once
        for (int i = 0; i < TB_NUM_OPS; i++) begin
            ops[i] = TB_OPS[i];
            if (TB_RANDOM_ROWS[i]) begin
                ops[i].data = {$urandom, $urandom};
            end
        end
        for (int k = 0; k < MODEL_WORDS * 8; k++) begin
            ref_mem[k] = 8'h00;
        end

        // done levels stay low through reset and just after it
        @(negedge clock);
        while (!reset) begin
            check_value("wr_ok_o", 64'd0, wr_ok);
            check_value("rw_ready_o", 64'd0, rw_ready);
            reset_edges++;
            if (reset_edges == RESET_CYCLES / 2) begin
                @(posedge clock);
                #1;
                wr_valid = 1'b0; // read of the first row takes over
                rw_valid = 1'b1;
            end
            @(negedge clock);
        end
        check_value("rw_ready_o", 64'd0, rw_ready);
        $display("reset: %s", row_errors == 0 ? "pass" : "fail");

        for (int i = 0; i < TB_NUM_OPS; i++) begin
            op = ops[i];
            row_errors = 0;
            done_name = op.is_write ? "wr_ok_o" : "rw_ready_o";
            @(posedge clock);
            #1;
            drive_row(op);
            if (prev_held) begin
                @(negedge clock);
                check_value("wr_ok_o", 64'd0, wr_ok); // address moved under a held request
            end
            wait_done(op.is_write, seen);
            if (!seen) begin
                errors++;
                row_errors++;
                $display("row %0d: request to address %h never completed", i, op.addr);
            end else begin
                if (op.is_write) begin
                    apply_write(op);
                end
                expect_data = predict_read(op.addr);
                for (int h = 0; h <= HOLD_CYCLES; h++) begin
                    if (h > 0) begin
                        @(negedge clock);
                    end
                    check_value(done_name, 64'd1, done_level(op.is_write));
                    if (!op.is_write) begin
                        check_value("data_read_o", expect_data, data_read);
                    end
                end
            end
            prev_held = (i == HELD_ROW) && op.is_write && seen;
            if (!prev_held) begin
                @(posedge clock);
                #1;
                wr_valid = 1'b0;
                rw_valid = 1'b0;
                @(negedge clock);
                check_value(done_name, 64'd0, done_level(op.is_write));
                @(posedge clock); // second idle cycle comes with the next row
            end
            $display("row %0d %s addr %h: %s", i, op.is_write ? "write" : "read",
                     op.addr, row_errors == 0 ? "pass" : "fail");
        end

        $display("rows %0d, checks %0d, errors %0d", TB_NUM_OPS, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
)(
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #2 clock_o = ~clock_o; // 4 ns period
    end

    // active low, released just after an edge
    initial begin
        reset_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        #1;
        reset_o = 1'b1;
    end

endmodule
